// File: src/axil_pause_pkg.sv
package axil_pause_pkg;

    // AXI-Lite field widths used on both ports.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  prot_t;
    typedef logic [1:0]  resp_t;

    // Write address channel payload.
    typedef struct packed {
        addr_t addr;
        prot_t prot;
    } axil_aw_t;

    // Write data channel payload.
    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    // Read address channel payload.
    typedef struct packed {
        addr_t addr;
        prot_t prot;
    } axil_ar_t;

    // Read data channel payload. The B channel carries a bare resp_t.
    typedef struct packed {
        data_t data;
        resp_t resp;
    } axil_r_t;

    // Pause controller states.
    typedef enum logic [1:0] {
        PAUSE_RUN   = 2'd0, // Traffic flows, no hold.
        PAUSE_DRAIN = 2'd1, // New beats held, waiting for open transactions to finish.
        PAUSE_HELD  = 2'd2  // Link idle and blocked, acknowledge given.
    } pause_state_e;

endpackage

// File: src/axil_write_gate.sv
`timescale 1ns/10ps

module axil_write_gate #(
    parameter int MAX_TRANS = 7
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    hold,
    output logic                    drained,

    input  axil_pause_pkg::axil_aw_t up_aw,
    input  logic                    up_aw_valid,
    output logic                    up_aw_ready,
    input  axil_pause_pkg::axil_w_t  up_w,
    input  logic                    up_w_valid,
    output logic                    up_w_ready,
    output axil_pause_pkg::resp_t    up_b,
    output logic                    up_b_valid,
    input  logic                    up_b_ready,

    output axil_pause_pkg::axil_aw_t dn_aw,
    output logic                    dn_aw_valid,
    input  logic                    dn_aw_ready,
    output axil_pause_pkg::axil_w_t  dn_w,
    output logic                    dn_w_valid,
    input  logic                    dn_w_ready,
    input  axil_pause_pkg::resp_t    dn_b,
    input  logic                    dn_b_valid,
    output logic                    dn_b_ready
);

    localparam int CNT_W = $clog2(MAX_TRANS + 1);

    typedef logic [CNT_W-1:0] cnt_t;

    cnt_t aw_ahead;  // AW beats still waiting for their W.
    cnt_t w_ahead;   // W beats still waiting for their AW.
    cnt_t open_cnt;  // Writes started but not yet answered upstream.
    cnt_t aw_ahead_n;
    cnt_t w_ahead_n;
    cnt_t open_n;

    logic full;
    logic aw_pass;
    logic w_pass;
    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic wr_start;

    assign full = (open_cnt == cnt_t'(MAX_TRANS));

    // A beat that completes a half-accepted write is always let through.
    assign aw_pass = (w_ahead != '0) || !(full || hold);
    assign w_pass  = (aw_ahead != '0) || !(full || hold);

    assign dn_aw       = up_aw;
    assign dn_aw_valid = up_aw_valid & aw_pass;
    assign up_aw_ready = dn_aw_ready & aw_pass;

    assign dn_w        = up_w;
    assign dn_w_valid  = up_w_valid & w_pass;
    assign up_w_ready  = dn_w_ready & w_pass;

    assign up_b        = dn_b;     // Responses are never masked.
    assign up_b_valid  = dn_b_valid;
    assign dn_b_ready  = up_b_ready;

    assign aw_fire = up_aw_valid & up_aw_ready;
    assign w_fire  = up_w_valid & up_w_ready;
    assign b_fire  = up_b_valid & up_b_ready;

    // A new write opens whenever a beat does not pair with one already waiting.
    assign wr_start = (aw_fire && w_fire)
                   || (aw_fire && !w_fire && (w_ahead == '0))
                   || (w_fire && !aw_fire && (aw_ahead == '0));

    always_comb begin
        aw_ahead_n = aw_ahead;
        w_ahead_n  = w_ahead;
        if (aw_fire && !w_fire) begin
            if (w_ahead != '0) begin
                w_ahead_n = w_ahead - 1'b1;
            end else begin
                aw_ahead_n = aw_ahead + 1'b1;
            end
        end else if (w_fire && !aw_fire) begin
            if (aw_ahead != '0) begin
                aw_ahead_n = aw_ahead - 1'b1;
            end else begin
                w_ahead_n = w_ahead + 1'b1;
            end
        end
        case ({wr_start, b_fire})
            2'b10:   open_n = open_cnt + 1'b1;
            2'b01:   open_n = open_cnt - 1'b1;
            default: open_n = open_cnt;
        endcase
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            aw_ahead <= '0;
            w_ahead  <= '0;
            open_cnt <= '0;
        end else begin
            aw_ahead <= aw_ahead_n;
            w_ahead  <= w_ahead_n;
            open_cnt <= open_n;
        end
    end

    assign drained = (aw_ahead == '0) && (w_ahead == '0) && (open_cnt == '0);

endmodule

// File: src/axil_read_gate.sv
`timescale 1ns/10ps

module axil_read_gate #(
    parameter int MAX_TRANS = 7
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    hold,
    output logic                    drained,

    input  axil_pause_pkg::axil_ar_t up_ar,
    input  logic                    up_ar_valid,
    output logic                    up_ar_ready,
    output axil_pause_pkg::axil_r_t  up_r,
    output logic                    up_r_valid,
    input  logic                    up_r_ready,

    output axil_pause_pkg::axil_ar_t dn_ar,
    output logic                    dn_ar_valid,
    input  logic                    dn_ar_ready,
    input  axil_pause_pkg::axil_r_t  dn_r,
    input  logic                    dn_r_valid,
    output logic                    dn_r_ready
);

    localparam int CNT_W = $clog2(MAX_TRANS + 1);

    typedef logic [CNT_W-1:0] cnt_t;

    cnt_t open_cnt;  // Reads accepted whose data has not gone upstream yet.
    cnt_t open_n;

    logic ar_pass;
    logic ar_fire;
    logic r_fire;

    // Reads have a single address beat, so nothing can be left half done.
    assign ar_pass = !hold && (open_cnt != cnt_t'(MAX_TRANS));

    assign dn_ar       = up_ar;
    assign dn_ar_valid = up_ar_valid & ar_pass;
    assign up_ar_ready = dn_ar_ready & ar_pass;

    assign up_r        = dn_r;
    assign up_r_valid  = dn_r_valid;
    assign dn_r_ready  = up_r_ready;

    assign ar_fire = up_ar_valid & up_ar_ready;
    assign r_fire  = up_r_valid & up_r_ready;

    always_comb begin
        case ({ar_fire, r_fire})
            2'b10:   open_n = open_cnt + 1'b1;
            2'b01:   open_n = open_cnt - 1'b1;
            default: open_n = open_cnt; // Both or neither leave the count alone.
        endcase
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            open_cnt <= '0;
        end else begin
            open_cnt <= open_n;
        end
    end

    assign drained = (open_cnt == '0);

endmodule

// File: src/pause_ctrl.sv
`timescale 1ns/10ps

module pause_ctrl (
    input  logic seq,
    input  logic rst_n,
    input  logic pause_req,
    input  logic wr_drained,
    input  logic rd_drained,
    output logic hold,
    output logic pause_ack
);

    axil_pause_pkg::pause_state_e state;
    axil_pause_pkg::pause_state_e state_n;

    logic all_drained;

    assign all_drained = wr_drained & rd_drained;

    always_comb begin
        state_n = state;
        case (state)
            axil_pause_pkg::PAUSE_RUN: begin
                if (pause_req) begin
                    state_n = axil_pause_pkg::PAUSE_DRAIN;
                end
            end
            axil_pause_pkg::PAUSE_DRAIN: begin
                // Only the gates decide when the drain is over.
                if (all_drained) begin
                    state_n = axil_pause_pkg::PAUSE_HELD;
                end
            end
            axil_pause_pkg::PAUSE_HELD: begin
                if (!pause_req) begin
                    state_n = axil_pause_pkg::PAUSE_RUN;
                end
            end
            default: begin
                state_n = axil_pause_pkg::PAUSE_RUN;
            end
        endcase
    end

    // Outputs are flops loaded from the next state, so they change with it.
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state     <= axil_pause_pkg::PAUSE_RUN;
            hold      <= 1'b0;
            pause_ack <= 1'b0;
        end else begin
            state     <= state_n;
            hold      <= (state_n != axil_pause_pkg::PAUSE_RUN);
            pause_ack <= (state_n == axil_pause_pkg::PAUSE_HELD);
        end
    end

endmodule

// File: src/axil_pause.sv
`timescale 1ns/10ps

module axil_pause #(
    parameter int MAX_TRANS = 7 // Outstanding limit per direction.
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    pause_req,
    output logic                    pause_ack,

    input  axil_pause_pkg::axil_aw_t up_aw,
    input  logic                    up_aw_valid,
    output logic                    up_aw_ready,
    input  axil_pause_pkg::axil_w_t  up_w,
    input  logic                    up_w_valid,
    output logic                    up_w_ready,
    output axil_pause_pkg::resp_t    up_b,
    output logic                    up_b_valid,
    input  logic                    up_b_ready,
    input  axil_pause_pkg::axil_ar_t up_ar,
    input  logic                    up_ar_valid,
    output logic                    up_ar_ready,
    output axil_pause_pkg::axil_r_t  up_r,
    output logic                    up_r_valid,
    input  logic                    up_r_ready,

    output axil_pause_pkg::axil_aw_t dn_aw,
    output logic                    dn_aw_valid,
    input  logic                    dn_aw_ready,
    output axil_pause_pkg::axil_w_t  dn_w,
    output logic                    dn_w_valid,
    input  logic                    dn_w_ready,
    input  axil_pause_pkg::resp_t    dn_b,
    input  logic                    dn_b_valid,
    output logic                    dn_b_ready,
    output axil_pause_pkg::axil_ar_t dn_ar,
    output logic                    dn_ar_valid,
    input  logic                    dn_ar_ready,
    input  axil_pause_pkg::axil_r_t  dn_r,
    input  logic                    dn_r_valid,
    output logic                    dn_r_ready
);

    logic hold;
    logic wr_drained;
    logic rd_drained;

    axil_write_gate #(
        .MAX_TRANS (MAX_TRANS)
    ) u_write_gate (
        .seq         (seq),
        .rst_n       (rst_n),
        .hold        (hold),
        .drained     (wr_drained),
        .up_aw       (up_aw),
        .up_aw_valid (up_aw_valid),
        .up_aw_ready (up_aw_ready),
        .up_w        (up_w),
        .up_w_valid  (up_w_valid),
        .up_w_ready  (up_w_ready),
        .up_b        (up_b),
        .up_b_valid  (up_b_valid),
        .up_b_ready  (up_b_ready),
        .dn_aw       (dn_aw),
        .dn_aw_valid (dn_aw_valid),
        .dn_aw_ready (dn_aw_ready),
        .dn_w        (dn_w),
        .dn_w_valid  (dn_w_valid),
        .dn_w_ready  (dn_w_ready),
        .dn_b        (dn_b),
        .dn_b_valid  (dn_b_valid),
        .dn_b_ready  (dn_b_ready)
    );

    axil_read_gate #(
        .MAX_TRANS (MAX_TRANS)
    ) u_read_gate (
        .seq         (seq),
        .rst_n       (rst_n),
        .hold        (hold),
        .drained     (rd_drained),
        .up_ar       (up_ar),
        .up_ar_valid (up_ar_valid),
        .up_ar_ready (up_ar_ready),
        .up_r        (up_r),
        .up_r_valid  (up_r_valid),
        .up_r_ready  (up_r_ready),
        .dn_ar       (dn_ar),
        .dn_ar_valid (dn_ar_valid),
        .dn_ar_ready (dn_ar_ready),
        .dn_r        (dn_r),
        .dn_r_valid  (dn_r_valid),
        .dn_r_ready  (dn_r_ready)
    );

    // One hold line serves both gates, so reads and writes pause together.
    pause_ctrl u_pause_ctrl (
        .seq        (seq),
        .rst_n      (rst_n),
        .pause_req  (pause_req),
        .wr_drained (wr_drained),
        .rd_drained (rd_drained),
        .hold       (hold),
        .pause_ack  (pause_ack)
    );

endmodule

// File: test/axil_pause_asserts.sv
`timescale 1ns/10ps

module axil_pause_asserts #(
    parameter int MAX_TRANS = 7,
    parameter int CNT_W     = $clog2(MAX_TRANS + 1)
) (
    input logic                         seq,
    input logic                         rst_n,
    input axil_pause_pkg::pause_state_e state,
    input logic                         hold,
    input logic                         pause_ack,
    input logic                         wr_drained,
    input logic                         rd_drained,
    input logic [CNT_W-1:0]             wr_aw_ahead,
    input logic [CNT_W-1:0]             wr_w_ahead,
    input logic [CNT_W-1:0]             wr_open,
    input logic [CNT_W-1:0]             rd_open
);

    // The acknowledge needs hold up and only comes after the FSM has already left the run state.
    ack_with_hold: assert property (@(posedge seq) disable iff (!rst_n)
        pause_ack |-> (hold && ($past(state) != axil_pause_pkg::PAUSE_RUN)))
        else $error("pause_ack is high while hold is low or with no drain phase before it");

    counters_in_range: assert property (@(posedge seq) disable iff (!rst_n)
        (wr_open <= MAX_TRANS) && (rd_open <= MAX_TRANS)
        && (wr_aw_ahead <= MAX_TRANS) && (wr_w_ahead <= MAX_TRANS))
        else $error("a gate counter went past MAX_TRANS");

    ack_when_drained: assert property (@(posedge seq) disable iff (!rst_n)
        pause_ack |-> (wr_drained && rd_drained)) // Nothing may be open while paused.
        else $error("pause_ack is high while a gate still has open transactions");

endmodule

bind axil_pause axil_pause_asserts #(
    .MAX_TRANS (MAX_TRANS)
) u_asserts (
    .seq         (seq),
    .rst_n       (rst_n),
    .state       (u_pause_ctrl.state),
    .hold        (hold),
    .pause_ack   (pause_ack),
    .wr_drained  (wr_drained),
    .rd_drained  (rd_drained),
    .wr_aw_ahead (u_write_gate.aw_ahead),
    .wr_w_ahead  (u_write_gate.w_ahead),
    .wr_open     (u_write_gate.open_cnt),
    .rd_open     (u_read_gate.open_cnt)
);

// File: test/axil_pause_tb.sv
`timescale 1ns/10ps

module axil_pause_tb;

    localparam int MAX_TRANS   = 7;
    localparam int ROUNDS      = 40;
    localparam int CYCLE_LIMIT = ROUNDS * 400 + 2000;

    logic seq;
    logic rst_n;
    logic pause_req;
    logic pause_ack;

    axil_pause_pkg::axil_aw_t up_aw, dn_aw;
    axil_pause_pkg::axil_w_t  up_w, dn_w;
    axil_pause_pkg::axil_ar_t up_ar, dn_ar;
    axil_pause_pkg::resp_t    up_b, dn_b;
    axil_pause_pkg::axil_r_t  up_r, dn_r;
    logic up_aw_valid, up_aw_ready, dn_aw_valid, dn_aw_ready;
    logic up_w_valid, up_w_ready, dn_w_valid, dn_w_ready;
    logic up_ar_valid, up_ar_ready, dn_ar_valid, dn_ar_ready;
    logic up_b_valid, up_b_ready, dn_b_valid, dn_b_ready;
    logic up_r_valid, up_r_ready, dn_r_valid, dn_r_ready;

    // Channels 0 to 4 are AW, W, AR, B and R.
    logic [63:0] exp_q [0:4][$];
    int          dn_cnt [0:4] = '{0, 0, 0, 0, 0}; // Beats that reached their far side.
    string       ch_name [0:4] = '{"dn_aw", "dn_w", "dn_ar", "up_b", "up_r"};
    string       test_name [1:6] = '{"payload order", "outstanding limit", "drained at ack",
                                     "no traffic while held", "release timing",
                                     "half writes complete"};
    int          err [1:6] = '{0, 0, 0, 0, 0, 0};
    int          checks = 0;
    int          cycles = 0;
    int          b_sent = 0;
    int          r_sent = 0;
    logic        aw_fire = 1'b0;
    logic        w_fire = 1'b0;
    logic        ar_fire = 1'b0;
    logic        b_fire = 1'b0;
    logic        r_fire = 1'b0;
    logic        dn_b_fire = 1'b0;
    logic        dn_r_fire = 1'b0;

    axil_pause #(
        .MAX_TRANS (MAX_TRANS)
    ) u_dut (.*);

    initial begin
        seq = 1'b0;
        forever #50 seq = ~seq;
    end

    function automatic logic chance(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic int open_writes();
        return ((dn_cnt[0] > dn_cnt[1]) ? dn_cnt[0] : dn_cnt[1]) - dn_cnt[3];
    endfunction

    function automatic int open_reads();
        return dn_cnt[2] - dn_cnt[4];
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge seq);
            #10;
        end
    endtask

    task automatic check_int(input int test, input string name, input int exp, input int got);
        checks++;
        if (got != exp) begin
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
            err[test]++;
        end
    endtask

    // Pops the oldest beat sent into a channel and compares it with what came out.
    task automatic take_beat(input int ch, input logic [63:0] got);
        logic [63:0] exp;
        checks++;
        dn_cnt[ch]++;
        if (exp_q[ch].size() == 0) begin
            $display("At %0t a %s beat came out that was never sent in", $time, ch_name[ch]);
            err[1]++;
        end else begin
            exp = exp_q[ch].pop_front();
            if (got != exp) begin
                $display("Mismatch at %0t: %s expected %h got %h", $time, ch_name[ch], exp, got);
                err[1]++;
            end
        end
    endtask

    // Handshakes are sampled mid-cycle, where every input and output is settled.
    always @(negedge seq) begin
        if (rst_n) begin
            aw_fire   = up_aw_valid && up_aw_ready;
            w_fire    = up_w_valid && up_w_ready;
            ar_fire   = up_ar_valid && up_ar_ready;
            b_fire    = up_b_valid && up_b_ready;
            r_fire    = up_r_valid && up_r_ready;
            dn_b_fire = dn_b_valid && dn_b_ready;
            dn_r_fire = dn_r_valid && dn_r_ready;
            if (aw_fire) exp_q[0].push_back(64'(up_aw));
            if (w_fire) exp_q[1].push_back(64'(up_w));
            if (ar_fire) exp_q[2].push_back(64'(up_ar));
            if (dn_aw_valid && dn_aw_ready) take_beat(0, 64'(dn_aw));
            if (dn_w_valid && dn_w_ready) take_beat(1, 64'(dn_w));
            if (dn_ar_valid && dn_ar_ready) take_beat(2, 64'(dn_ar));
            if (b_fire) take_beat(3, 64'(up_b));
            if (r_fire) take_beat(4, 64'(up_r));
            checks++;
            if (open_writes() > MAX_TRANS || open_reads() > MAX_TRANS) begin
                $display("At %0t the open count went past %0d (writes %0d, reads %0d)",
                         $time, MAX_TRANS, open_writes(), open_reads());
                err[2]++;
            end
            checks++;
            if (pause_ack && (aw_fire || w_fire || ar_fire || (dn_aw_valid && dn_aw_ready)
                              || (dn_w_valid && dn_w_ready) || (dn_ar_valid && dn_ar_ready))) begin
                $display("At %0t an AW, W or AR handshake happened while paused", $time);
                err[4]++;
            end
        end
    end

    // Upstream manager and downstream responder, both driven just after the edge.
    always @(posedge seq) begin
        if (rst_n) begin
            #10;
            if (aw_fire || !up_aw_valid) begin
                up_aw       = {32'($urandom), 3'($urandom)};
                up_aw_valid = chance(40);
            end
            if (w_fire || !up_w_valid) begin
                up_w       = {32'($urandom), 4'($urandom)};
                up_w_valid = chance(40);
            end
            if (ar_fire || !up_ar_valid) begin
                up_ar       = {32'($urandom), 3'($urandom)};
                up_ar_valid = chance(40);
            end
            up_b_ready  = chance(70);
            up_r_ready  = chance(70);
            dn_aw_ready = chance(60);
            dn_w_ready  = chance(60);
            dn_ar_ready = chance(60);
            if (dn_b_fire) dn_b_valid = 1'b0;
            if (!dn_b_valid && chance(50)
                && (((dn_cnt[0] < dn_cnt[1]) ? dn_cnt[0] : dn_cnt[1]) > b_sent)) begin
                dn_b       = 2'($urandom); // One B per complete AW and W pair.
                dn_b_valid = 1'b1;
                exp_q[3].push_back(64'(dn_b));
                b_sent++;
            end
            if (dn_r_fire) dn_r_valid = 1'b0;
            if (!dn_r_valid && chance(50) && (dn_cnt[2] > r_sent)) begin
                dn_r       = {32'($urandom), 2'($urandom)};
                dn_r_valid = 1'b1;
                exp_q[4].push_back(64'(dn_r));
                r_sent++;
            end
        end
    end

    always @(posedge seq) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int start_txn;
        int wait_n;
        int total;
        void'($urandom(32'h293));
        rst_n     = 1'b0;
        pause_req = 1'b0;
        up_aw     = '0;
        up_w      = '0;
        up_ar     = '0;
        dn_b      = '0;
        dn_r      = '0;
        {up_aw_valid, up_w_valid, up_ar_valid, up_b_ready, up_r_ready} = '0;
        {dn_aw_ready, dn_w_ready, dn_ar_ready, dn_b_valid, dn_r_valid} = '0;
        repeat (2) @(posedge seq);
        #10;
        rst_n = 1'b1;
        for (int round = 0; round < ROUNDS; round++) begin
            wait_cycles($urandom_range(30, 1));
            pause_req = 1'b1;
            do begin
                wait_cycles(1);
            end while (!pause_ack);
            check_int(3, "open_writes", 0, open_writes());
            check_int(3, "open_reads", 0, open_reads());
            check_int(6, "w_count", dn_cnt[0], dn_cnt[1]);
            check_int(6, "b_count", dn_cnt[0], dn_cnt[3]);
            if (round == ROUNDS - 1) begin
                for (int ch = 0; ch < 5; ch++) begin
                    check_int(1, {ch_name[ch], "_pending"}, 0, exp_q[ch].size());
                end
            end
            wait_cycles($urandom_range(20, 1));
            pause_req = 1'b0;
            wait_cycles(1); // The ack drops at the first edge that sees the request low.
            check_int(5, "pause_ack", 0, pause_ack);
            start_txn = dn_cnt[0] + dn_cnt[1] + dn_cnt[2];
            wait_n    = 0;
            while ((dn_cnt[0] + dn_cnt[1] + dn_cnt[2] == start_txn) && (wait_n < 200)) begin
                wait_cycles(1);
                wait_n++;
            end
            checks++;
            if (wait_n == 200) begin
                $display("No transaction went through after the release in round %0d", round);
                err[5]++;
            end
        end
        total = 0;
        for (int t = 1; t <= 6; t++) begin
            $display("Test %0d %s: %s (%0d errors)", t, test_name[t],
                     (err[t] == 0) ? "ok" : "bad", err[t]);
            total += err[t];
        end
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, total, cycles);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: all.f
src/axil_pause_pkg.sv
src/axil_write_gate.sv
src/axil_read_gate.sv
src/pause_ctrl.sv
src/axil_pause.sv
test/axil_pause_asserts.sv
test/axil_pause_tb.sv
